// File: src/icachePkg.sv
/* Cache geometry and controller state encoding shared by the instruction cache RTL.
   Import into a module header wherever a width or the state type is needed. */
package icachePkg;

    // fetch side
    localparam int ADDR_W       = 32;
    localparam int WORD_W       = 32;

    // block layout
    localparam int BLOCK_WORDS  = 4;
    localparam int BLOCK_BITS   = BLOCK_WORDS * WORD_W;
    localparam int OFFSET_W     = 4;
    localparam int WORD_SEL_W   = $clog2(BLOCK_WORDS);

    // organisation of the array
    localparam int WAYS         = 4;
    localparam int SETS         = 16;
    localparam int INDEX_W      = $clog2(SETS);

    // address split: tag | index | byte offset
    localparam int TAG_W        = ADDR_W - INDEX_W - OFFSET_W;
    localparam int BLOCK_ADDR_W = TAG_W + INDEX_W;

    // hit and miss counters wrap around
    localparam int CNT_W        = 16;

    // controller states
    // stMemWait holds memReq until the block comes back,
    // stFill spends exactly one cycle writing it into the array
    typedef enum logic [1:0] {
        stIdle    = 2'd0,
        stMemWait = 2'd1,
        stFill    = 2'd2
    } ctrlState;

endpackage

// File: src/icacheArray.sv
/* Set-associative tag/data store with valid and MRU status bits per way.
   Lookup is combinational from blockAddr; status and refill writes land on the clock. */
module icacheArray import icachePkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ren,
    input  logic                    memWen,
    input  logic [BLOCK_ADDR_W-1:0] blockAddr,
    input  logic [BLOCK_BITS-1:0]   dataIn,
    output logic                    hit,
    output logic [BLOCK_BITS-1:0]   dataOut
);

    // per set: one valid and one status bit for every way
    logic [WAYS-1:0]       validBits  [SETS];
    logic [WAYS-1:0]       statusBits [SETS];
    logic [TAG_W-1:0]      tagMem     [SETS][WAYS];
    logic [BLOCK_BITS-1:0] dataMem    [SETS][WAYS];

    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0]   tag;
    logic [WAYS-1:0]    hitWays;
    logic [WAYS-1:0]    victimWay;
    logic [WAYS-1:0]    accessWay;
    logic [WAYS-1:0]    touchedStatus;
    logic [WAYS-1:0]    nextStatus;

    // block address is tag on top, index below
    assign index = blockAddr[INDEX_W-1:0];
    assign tag   = blockAddr[BLOCK_ADDR_W-1:INDEX_W];

    // tag compare across the ways of the addressed set
    always_comb begin
        hitWays = '0;
        dataOut = '0;
        for (int w = 0; w < WAYS; w++) begin
            hitWays[w] = validBits[index][w] && (tagMem[index][w] == tag);
            if (hitWays[w]) begin
                dataOut = dataMem[index][w];
            end
        end
    end

    assign hit = |hitWays;

    // victim choice, one-hot
    // walking downwards leaves the lowest matching way selected
    always_comb begin
        victimWay = WAYS'(1);
        if (!(&validBits[index])) begin
            // an empty way is always preferred
            for (int w = WAYS - 1; w >= 0; w--) begin
                if (!validBits[index][w]) begin
                    victimWay    = '0;
                    victimWay[w] = 1'b1;
                end
            end
        end else begin
            // set full, take the lowest way not recently used
            for (int w = WAYS - 1; w >= 0; w--) begin
                if (!statusBits[index][w]) begin
                    victimWay    = '0;
                    victimWay[w] = 1'b1;
                end
            end
        end
    end

    // MRU update for the way being touched this cycle
    assign accessWay     = ren ? hitWays : victimWay;
    assign touchedStatus = statusBits[index] | accessWay;

    // all ones would leave no victim, so keep only the touched way
    assign nextStatus = (&touchedStatus) ? accessWay : touchedStatus;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < SETS; s++) begin
                validBits[s]  <= '0;
                statusBits[s] <= '0;
                for (int w = 0; w < WAYS; w++) begin
                    tagMem[s][w]  <= '0;
                    dataMem[s][w] <= '0;
                end
            end
        end else if (ren) begin
            // read side wins over a refill
            if (hit) begin
                statusBits[index] <= nextStatus;
            end
        end else if (memWen) begin
            validBits[index]  <= validBits[index] | victimWay;
            statusBits[index] <= nextStatus;
            for (int w = 0; w < WAYS; w++) begin
                if (victimWay[w]) begin
                    tagMem[index][w]  <= tag;
                    dataMem[index][w] <= dataIn;
                end
            end
        end
    end

endmodule

// File: src/icacheCtrl.sv
/* Miss handling FSM in front of the array: serves hits in the same cycle,
   fetches a missing block from memory, refills it and counts hits and misses. */
module icacheCtrl import icachePkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fetchReq,
    input  logic [ADDR_W-1:0]       fetchAddr,
    input  logic                    hit,
    input  logic [BLOCK_BITS-1:0]   dataOut,
    input  logic                    memValid,
    input  logic [BLOCK_BITS-1:0]   memData,
    output logic                    fetchValid,
    output logic [WORD_W-1:0]       fetchData,
    output logic                    ren,
    output logic                    memWen,
    output logic [BLOCK_ADDR_W-1:0] blockAddr,
    output logic [BLOCK_BITS-1:0]   dataIn,
    output logic                    memReq,
    output logic [BLOCK_ADDR_W-1:0] memAddr,
    output logic [CNT_W-1:0]        hitCount,
    output logic [CNT_W-1:0]        missCount
);

    ctrlState state;
    ctrlState stateNext;

    logic [BLOCK_ADDR_W-1:0] reqBlock;
    logic [BLOCK_ADDR_W-1:0] missAddr;
    logic [BLOCK_BITS-1:0]   fillData;
    logic [WORD_SEL_W-1:0]   wordSel;
    logic                    lookup;
    logic                    missStart;

    assign reqBlock = fetchAddr[ADDR_W-1:OFFSET_W];
    assign wordSel  = fetchAddr[OFFSET_W-1:OFFSET_W-WORD_SEL_W];

    // array is only read while idle with a fetch pending
    assign lookup    = (state == stIdle) && fetchReq;
    assign missStart = lookup && !hit;

    assign ren        = lookup;
    assign fetchValid = lookup && hit;
    assign fetchData  = dataOut[wordSel*WORD_W +: WORD_W];

    // idle looks up the live address, otherwise the latched miss block
    assign blockAddr = (state == stIdle) ? reqBlock : missAddr;
    assign memAddr   = missAddr;
    assign dataIn    = fillData;

    assign memReq = (state == stMemWait);
    assign memWen = (state == stFill);

    always_comb begin
        stateNext = state;
        case (state)
            stIdle: begin
                if (missStart) begin
                    stateNext = stMemWait;
                end
            end
            stMemWait: begin
                // memory latency is not fixed, wait for the strobe
                if (memValid) begin
                    stateNext = stFill;
                end
            end
            stFill: begin
                stateNext = stIdle;
            end
            default: begin
                stateNext = stIdle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= stIdle;
        end else begin
            state <= stateNext;
        end
    end

    // block address and returned line
    always_ff @(posedge clk) begin
        if (missStart) begin
            missAddr <= reqBlock;
        end
        if (memReq && memValid) begin
            fillData <= memData;
        end
    end

    // completing fetch after a refill counts as a hit here
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            hitCount  <= '0;
            missCount <= '0;
        end else begin
            if (fetchValid) begin
                hitCount <= hitCount + 1'b1;
            end
            if (missStart) begin
                missCount <= missCount + 1'b1;
            end
        end
    end

endmodule

// File: src/icacheTop.sv
/* Instruction cache top: controller plus tag/data array.
   Fetch port toward the CPU, block request port toward backing memory. */
module icacheTop import icachePkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fetchReq,
    input  logic [ADDR_W-1:0]       fetchAddr,
    input  logic                    memValid,
    input  logic [BLOCK_BITS-1:0]   memData,
    output logic                    fetchValid,
    output logic [WORD_W-1:0]       fetchData,
    output logic                    memReq,
    output logic [BLOCK_ADDR_W-1:0] memAddr,
    output logic [CNT_W-1:0]        hitCount,
    output logic [CNT_W-1:0]        missCount
);

    // controller to array
    logic                    ren;
    logic                    memWen;
    logic [BLOCK_ADDR_W-1:0] blockAddr;
    logic [BLOCK_BITS-1:0]   dataIn;
    logic                    hit;
    logic [BLOCK_BITS-1:0]   dataOut;

    icacheCtrl ctrl0 (
        .clk        (clk),
        .rst        (rst),
        .fetchReq   (fetchReq),
        .fetchAddr  (fetchAddr),
        .hit        (hit),
        .dataOut    (dataOut),
        .memValid   (memValid),
        .memData    (memData),
        .fetchValid (fetchValid),
        .fetchData  (fetchData),
        .ren        (ren),
        .memWen     (memWen),
        .blockAddr  (blockAddr),
        .dataIn     (dataIn),
        .memReq     (memReq),
        .memAddr    (memAddr),
        .hitCount   (hitCount),
        .missCount  (missCount)
    );

    icacheArray array0 (
        .clk       (clk),
        .rst       (rst),
        .ren       (ren),
        .memWen    (memWen),
        .blockAddr (blockAddr),
        .dataIn    (dataIn),
        .hit       (hit),
        .dataOut   (dataOut)
    );

endmodule

// File: bench/clkGen.sv
/* Testbench clock with a 4 ns period and an active-low reset
   that is held for the first 16 cycles. */
module clkGen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // release on a falling edge, away from the flops
    initial begin
        rst = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
    end
endmodule

// File: bench/icacheCtrl_chk.sv
/* Concurrent assertions on the cache controller strobes.
   Bound into every icacheCtrl instance next to its FSM state. */
module icacheCtrl_chk import icachePkg::*; (
    input logic     clk,
    input logic     rst,
    input logic     ren,
    input logic     memWen,
    input logic     memReq,
    input logic     memValid,
    input logic     fetchReq,
    input logic     fetchValid,
    input ctrlState state
);
    timeunit 1ns;
    timeprecision 100ps;

    int assertFails = 0;

    // array read and refill never share a cycle
    readOrFill: assert property (@(posedge clk) disable iff (!rst) !(ren && memWen))
        else begin
            $error("ren and memWen are high in the same cycle");
            assertFails++;
        end

    // request level holds until the memory answers
    reqHeld: assert property (@(posedge clk) disable iff (!rst) memReq && !memValid |=> memReq)
        else begin
            $error("memReq dropped before memValid");
            assertFails++;
        end

    // refill write comes straight out of memory wait and lasts one cycle
    fillPulse: assert property (@(posedge clk) disable iff (!rst)
        memWen |-> $past(state) == stMemWait ##1 !memWen)
        else begin
            $error("memWen not right after memory wait or longer than one cycle");
            assertFails++;
        end

    fetchPaired: assert property (@(posedge clk) disable iff (!rst) fetchValid |-> fetchReq)
        else begin
            $error("fetchValid without fetchReq");
            assertFails++;
        end
endmodule

bind icacheCtrl icacheCtrl_chk ctrlChk0 (
    .clk        (clk),
    .rst        (rst),
    .ren        (ren),
    .memWen     (memWen),
    .memReq     (memReq),
    .memValid   (memValid),
    .fetchReq   (fetchReq),
    .fetchValid (fetchValid),
    .state      (state)
);

// File: bench/icacheTb.sv
/* Instruction cache testbench that replays fetch vectors from a file, models the
   backing memory with random latency and checks data, hit flags and counters. */
module icacheTb import icachePkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    logic                    clk;
    logic                    rst;
    logic                    fetchReq;
    logic [ADDR_W-1:0]       fetchAddr;
    logic                    memValid = 1'b0;
    logic [BLOCK_BITS-1:0]   memData = '0;
    logic                    fetchValid;
    logic [WORD_W-1:0]       fetchData;
    logic                    memReq;
    logic [BLOCK_ADDR_W-1:0] memAddr;
    logic [CNT_W-1:0]        hitCount;
    logic [CNT_W-1:0]        missCount;

    logic [7:0] lfsrState = 8'd93;
    logic       memBusy = 1'b0;
    int         memDelay = 0;
    int         errors;
    int         testCount;
    int         expHits;
    int         expMisses;
    logic       aborted;

    clkGen clkGen0 (
        .clk (clk),
        .rst (rst)
    );

    icacheTop dut0 (
        .clk        (clk),
        .rst        (rst),
        .fetchReq   (fetchReq),
        .fetchAddr  (fetchAddr),
        .memValid   (memValid),
        .memData    (memData),
        .fetchValid (fetchValid),
        .fetchData  (fetchData),
        .memReq     (memReq),
        .memAddr    (memAddr),
        .hitCount   (hitCount),
        .missCount  (missCount)
    );

    // 8-bit Fibonacci LFSR with taps 8 6 5 4
    function automatic logic [7:0] lfsrNext(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic drawDelay(output int cycles);
        logic [2:0] bits;
        bits = '0;
        for (int i = 0; i < 3; i++) begin
            lfsrState = lfsrNext(lfsrState);
            bits = {bits[1:0], lfsrState[0]};
        end
        cycles = int'(bits) + 1;
    endtask

    // word k of block B as the memory holds it
    function automatic logic [WORD_W-1:0] ruleWord(input logic [BLOCK_ADDR_W-1:0] blk,
                                                   input logic [1:0] k);
        return ({blk, 4'h0} + {30'd0, k}) ^ 32'hC0DE0000;
    endfunction

    task automatic checkValue(input string name, input logic [127:0] actual,
                              input logic [127:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0d ns: %s is %0h, expected %0h", $time, name, actual, expected);
            errors++;
        end
    endtask

    // backing memory that answers each request after 1 to 8 cycles
    always @(negedge clk) begin
        memValid = 1'b0;
        if (memReq === 1'b1 && !memBusy) begin
            memBusy = 1'b1;
            drawDelay(memDelay);
        end
        if (memBusy) begin
            memDelay = memDelay - 1;
            if (memDelay == 0) begin
                for (int k = 0; k < BLOCK_WORDS; k++) begin
                    memData[k*WORD_W +: WORD_W] = ruleWord(memAddr, 2'(k));
                end
                memValid = 1'b1;
                memBusy  = 1'b0;
            end
        end
    end

    // entered and left on a falling edge
    task automatic runFetch(input logic [ADDR_W-1:0] addr, input logic expHit,
                            output logic timedOut);
        logic              sawReq;
        logic              done;
        logic [WORD_W-1:0] word;
        int                cycles;
        int                errBefore;
        sawReq    = 1'b0;
        done      = 1'b0;
        word      = '0;
        cycles    = 0;
        errBefore = errors;
        fetchReq  = 1'b1;
        fetchAddr = addr;
        while (!done && cycles < 200) begin
            // sample just ahead of the rising edge
            #1;
            if (memReq === 1'b1 && !sawReq) begin
                checkValue("memAddr", 128'(memAddr), 128'(addr[ADDR_W-1:OFFSET_W]));
                sawReq = 1'b1;
            end
            if (fetchValid === 1'b1) begin
                done = 1'b1;
                word = fetchData;
            end
            @(negedge clk);
            cycles++;
        end
        fetchReq = 1'b0;
        timedOut = !done;
        if (!done) begin
            $display("timeout: no fetchValid within 200 cycles for address %h", addr);
        end else begin
            testCount++;
            expHits++;
            if (!expHit) begin
                expMisses++;
            end
            checkValue("fetchData", 128'(word), 128'(ruleWord(addr[31:4], addr[3:2])));
            checkValue("hit", 128'(!sawReq), 128'(expHit));
            if (expHit) begin
                // a hit is served in the cycle of the request
                checkValue("fetchValid cycles", 128'(cycles), 128'(1));
            end
            checkValue("hitCount", 128'(hitCount), 128'(expHits));
            checkValue("missCount", 128'(missCount), 128'(expMisses));
            $display("fetch %0d at %h, %s: %s", testCount, addr, expHit ? "hit" : "miss",
                     (errors == errBefore) ? "ok" : "mismatch");
        end
    endtask

    task automatic runVectors(output logic stop);
        int                fd;
        int                fields;
        int                flag;
        string             line;
        logic [ADDR_W-1:0] addr;
        stop = 1'b0;
        fd = $fopen("bench/fetchVectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file bench/fetchVectors.txt");
            stop = 1'b1;
        end else begin
            while (!stop && $fgets(line, fd) > 0) begin
                if (line.len() > 0 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%h %d", addr, flag);
                    if (fields == 2) begin
                        runFetch(addr, flag != 0, stop);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        int cycles;
        fetchReq  = 1'b0;
        fetchAddr = '0;
        errors    = 0;
        testCount = 0;
        expHits   = 0;
        expMisses = 0;
        aborted   = 1'b1;
        cycles    = 0;
        while (aborted && cycles < 200) begin
            @(negedge clk);
            #1;
            aborted = (rst !== 1'b1);
            cycles++;
        end
        if (aborted) begin
            $display("timeout: reset was never released");
        end else begin
            @(negedge clk);
            checkValue("memReq", 128'(memReq), 128'(0));
            checkValue("fetchValid", 128'(fetchValid), 128'(0));
            checkValue("hitCount", 128'(hitCount), 128'(0));
            checkValue("missCount", 128'(missCount), 128'(0));
            runVectors(aborted);
        end
        if (!aborted && testCount == 0) begin
            $display("no fetch vectors were found in the vector file");
            aborted = 1'b1;
        end
        errors += dut0.ctrl0.ctrlChk0.assertFails;
        $display("fetches %0d, errors %0d, hitCount %0d, missCount %0d",
                 testCount, errors, hitCount, missCount);
        if (errors == 0 && !aborted) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end
endmodule

// File: bench/fetchVectors.txt
# columns: fetch address (hex), expected hit flag (1 hit, 0 miss)
# set index is address bits 7:4, tag is bits 31:8
# cold misses in four sets
00001000 0
00001014 0
00001028 0
0000103C 0
# hits on resident blocks
00001004 1
0000102C 1
00001038 1
# fill set 0 with three more tags, then refetch all four ways
00002000 0
00003004 0
00004008 0
0000100C 1
00002004 1
00003008 1
0000400C 1
# replacement in set 0 following the MRU bits
00002000 1
00005000 0
00001000 0
00002000 0
00004000 1
00005004 1
00003000 0
00002008 1
00001000 0
0000400C 1
00005000 0
# misses in other sets under varying memory latency
00008040 0
0000807C 0
00008048 1
ABCDE0A8 0
ABCDE0A4 1

// File: tb.f
src/icachePkg.sv
src/icacheArray.sv
src/icacheCtrl.sv
src/icacheTop.sv
bench/clkGen.sv
bench/icacheCtrl_chk.sv
bench/icacheTb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/100ps
TOP       = icacheTb
RTL_TOP   = icacheTop
FILELIST  = tb.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --timescale 1ns/100ps --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
